// ==== design/pmp_config.svh ====
// PALEN is fixed at 32; PMP_ENTRIES must be a multiple of 4 no larger than 32
`ifndef PMP_CONFIG_SVH
`define PMP_CONFIG_SVH

// implemented entries, the rest of the 32 architectural entries read as zero
`define PMP_ENTRIES      8
`define PMP_GRANULARITY  16
`define PMP_G            ($clog2(`PMP_GRANULARITY) - 2)
`define PMP_PALEN        32

// architectural CSR map
`define PMP_CFG_BASE     12'h3A0
`define PMP_ADDR_BASE    12'h3B0
`define PMP_CFG_CSRS     8
`define PMP_ADDR_CSRS    32

// fields of a configuration byte, bits 6:5 are reserved
`define PMPCFG_L         7
`define PMPCFG_A_MSB     4
`define PMPCFG_A_LSB     3
`define PMPCFG_X         2
`define PMPCFG_W         1
`define PMPCFG_R         0

// address matching modes in the A field
`define PMP_A_OFF        2'b00
`define PMP_A_TOR        2'b01
`define PMP_A_NA4        2'b10
`define PMP_A_NAPOT      2'b11

`define PRIV_MACHINE     2'b11

`endif

// ==== design/pmp_pkg.sv ====
// types shared by the PMP CSR blocks; the address word width follows PMP_PALEN
`include "pmp_config.svh"

package pmp_pkg;

    // CSR bus
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // current privilege level of the hart
    typedef logic [1:0] priv_t;

    // A field of a configuration byte
    typedef logic [1:0] pmp_mode_t;

    // one configuration byte as stored and exported
    typedef logic [7:0] pmp_cfg_t;

    // stored address word holds physical address bits PALEN-1:2
    typedef logic [`PMP_PALEN-3:0] pmp_addr_t;

endpackage

// ==== design/pmp_csr_decode.sv ====
// write qualification is purely combinational and assumes a single-cycle write strobe
`timescale 1ns/1ps
`include "pmp_config.svh"

module pmp_csr_decode (
    input  logic                                 csr_pmp_we,
    input  pmp_pkg::csr_addr_t                   csr_pmp_waddr,
    input  pmp_pkg::csr_data_t                   csr_pmp_wdata,
    input  pmp_pkg::priv_t                       csr_cur_privilege,
    input  pmp_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0] entry_cfg,
    output logic [`PMP_ENTRIES-1:0]              cfg_we,
    output logic [`PMP_ENTRIES-1:0]              addr_we,
    output pmp_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0] cfg_wdata
);
    import pmp_pkg::*;

    logic                    wr_allowed;
    logic [`PMP_ENTRIES-1:0] entry_locked;
    logic [`PMP_ENTRIES-1:0] tor_locked;

    // only machine mode may touch the PMP registers
    assign wr_allowed = csr_pmp_we && (csr_cur_privilege == `PRIV_MACHINE);

    for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : gen_entry
        // four entries share one cfg CSR, each addr CSR belongs to one entry
        localparam csr_addr_t CFG_CSR  = csr_addr_t'(`PMP_CFG_BASE + i / 4);
        localparam csr_addr_t ADDR_CSR = csr_addr_t'(`PMP_ADDR_BASE + i);

        pmp_cfg_t  lane;
        pmp_mode_t lane_mode;
        logic      next_tor_locked;

        assign entry_locked[i] = entry_cfg[i][`PMPCFG_L];
        assign tor_locked[i]   = entry_cfg[i][`PMPCFG_L] &&
                                 (entry_cfg[i][`PMPCFG_A_MSB:`PMPCFG_A_LSB] == `PMP_A_TOR);

        // a locked TOR entry also protects the address word just below it
        if (i < `PMP_ENTRIES - 1) begin : gen_next
            assign next_tor_locked = tor_locked[i + 1];
        end else begin : gen_last
            assign next_tor_locked = 1'b0;
        end

        assign cfg_we[i]  = wr_allowed && (csr_pmp_waddr == CFG_CSR) && !entry_locked[i];
        assign addr_we[i] = wr_allowed && (csr_pmp_waddr == ADDR_CSR) && !entry_locked[i] &&
                            !next_tor_locked;

        // byte lane of this entry within its cfg CSR
        assign lane = csr_pmp_wdata[8 * (i % 4) +: 8];

        // NA4 is not supported at this granularity and is stored as OFF
        assign lane_mode = (lane[`PMPCFG_A_MSB:`PMPCFG_A_LSB] == `PMP_A_NA4) ?
                           `PMP_A_OFF : lane[`PMPCFG_A_MSB:`PMPCFG_A_LSB];

        assign cfg_wdata[i] = {
            lane[`PMPCFG_L],
            2'b00,
            lane_mode,
            lane[`PMPCFG_X],
            lane[`PMPCFG_W],
            lane[`PMPCFG_R]
        };
    end

endmodule

// ==== design/pmp_entry_regs.sv ====
// entry registers reset to zero and load one cycle after their enable; no write priority needed
`timescale 1ns/1ps
`include "pmp_config.svh"

module pmp_entry_regs (
    input  logic                                  core_clk,
    input  logic                                  core_reset_n,
    input  logic [`PMP_ENTRIES-1:0]               cfg_we,
    input  logic [`PMP_ENTRIES-1:0]               addr_we,
    input  pmp_pkg::pmp_cfg_t  [`PMP_ENTRIES-1:0] cfg_wdata,
    input  pmp_pkg::csr_data_t                    csr_pmp_wdata,
    output pmp_pkg::pmp_cfg_t  [`PMP_ENTRIES-1:0] entry_cfg,
    output pmp_pkg::pmp_addr_t [`PMP_ENTRIES-1:0] entry_addr,
    output logic                                  pmp_we
);
    import pmp_pkg::*;

    pmp_addr_t addr_wdata;
    logic      any_we;

    // the CSR carries physical address bits PALEN-1:2 in its low bits
    assign addr_wdata = csr_pmp_wdata[`PMP_PALEN-3:0];

    assign any_we = (|cfg_we) || (|addr_we);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            entry_cfg  <= '0;
            entry_addr <= '0;
        end else begin
            for (int i = 0; i < `PMP_ENTRIES; i++) begin
                if (cfg_we[i]) begin
                    entry_cfg[i] <= cfg_wdata[i];
                end
                if (addr_we[i]) begin
                    entry_addr[i] <= addr_wdata;
                end
            end
        end
    end

    // pulse for the checker stage, high for the cycle after each accepted write
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            pmp_we <= 1'b0;
        end else begin
            pmp_we <= any_we;
        end
    end

endmodule

// ==== design/pmp_csr_read.sv ====
// reads are combinational over all 40 PMP CSRs; other addresses give hit low and zero data
`timescale 1ns/1ps
`include "pmp_config.svh"

module pmp_csr_read (
    input  pmp_pkg::csr_addr_t                    raddr0,
    input  pmp_pkg::csr_addr_t                    raddr1,
    input  pmp_pkg::pmp_cfg_t  [`PMP_ENTRIES-1:0] entry_cfg,
    input  pmp_pkg::pmp_addr_t [`PMP_ENTRIES-1:0] entry_addr,
    output logic                                  hit0,
    output logic                                  hit1,
    output pmp_pkg::csr_data_t                    rdata0,
    output pmp_pkg::csr_data_t                    rdata1
);
    import pmp_pkg::*;

    localparam int CFG_IDX_W  = $clog2(`PMP_CFG_CSRS);
    localparam int ADDR_IDX_W = $clog2(`PMP_ADDR_CSRS);

    // every architectural entry, unimplemented ones held at zero
    pmp_cfg_t  [4*`PMP_CFG_CSRS-1:0] cfg_all;
    csr_data_t [`PMP_ADDR_CSRS-1:0]  word_all;

    // granularity rule on the low PMP_G bits of an address read
    function automatic csr_data_t shape_addr(pmp_cfg_t cfg, pmp_addr_t addr);
        csr_data_t word;
        pmp_mode_t mode;
        word = csr_data_t'(addr);
        mode = cfg[`PMPCFG_A_MSB:`PMPCFG_A_LSB];
        if (mode == `PMP_A_NAPOT) begin
            // only bit G-1 keeps its stored value in NAPOT mode
            for (int b = 0; b < `PMP_G - 1; b++) begin
                word[b] = 1'b1;
            end
        end else begin
            for (int b = 0; b < `PMP_G; b++) begin
                word[b] = 1'b0;
            end
        end
        return word;
    endfunction

    function automatic logic csr_hit(csr_addr_t addr);
        csr_addr_t cfg_off;
        csr_addr_t addr_off;
        cfg_off  = addr - `PMP_CFG_BASE;
        addr_off = addr - `PMP_ADDR_BASE;
        return (cfg_off < csr_addr_t'(`PMP_CFG_CSRS)) ||
               (addr_off < csr_addr_t'(`PMP_ADDR_CSRS));
    endfunction

    function automatic csr_data_t read_csr(csr_addr_t                       addr,
                                           pmp_cfg_t [4*`PMP_CFG_CSRS-1:0] cfgs,
                                           csr_data_t [`PMP_ADDR_CSRS-1:0] words);
        csr_addr_t cfg_off;
        csr_addr_t addr_off;
        csr_data_t data;
        // addresses below a base wrap to large offsets and fall out of range
        cfg_off  = addr - `PMP_CFG_BASE;
        addr_off = addr - `PMP_ADDR_BASE;
        data     = '0;
        if (cfg_off < csr_addr_t'(`PMP_CFG_CSRS)) begin
            // lowest entry of the group lands in the lowest byte
            data = cfgs[4 * cfg_off[CFG_IDX_W-1:0] +: 4];
        end else if (addr_off < csr_addr_t'(`PMP_ADDR_CSRS)) begin
            data = words[addr_off[ADDR_IDX_W-1:0]];
        end
        return data;
    endfunction

    always_comb begin
        cfg_all  = '0;
        word_all = '0;
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            cfg_all[i]  = entry_cfg[i];
            word_all[i] = shape_addr(entry_cfg[i], entry_addr[i]);
        end
    end

    assign hit0   = csr_hit(raddr0);
    assign hit1   = csr_hit(raddr1);
    assign rdata0 = read_csr(raddr0, cfg_all, word_all);
    assign rdata1 = read_csr(raddr1, cfg_all, word_all);

endmodule

// ==== design/pmp_csr.sv ====
// PMP CSR file with one write port and two zero-latency read ports; writes show one cycle later
`timescale 1ns/1ps
`include "pmp_config.svh"

module pmp_csr (
    input  logic                                  core_clk,
    input  logic                                  core_reset_n,
    input  pmp_pkg::priv_t                        csr_cur_privilege,
    input  logic                                  csr_pmp_we,
    input  pmp_pkg::csr_addr_t                    csr_pmp_waddr,
    input  pmp_pkg::csr_data_t                    csr_pmp_wdata,
    input  pmp_pkg::csr_addr_t                    csr_pmp_raddr0,
    input  pmp_pkg::csr_addr_t                    csr_pmp_raddr1,
    output logic                                  pmp_csr_hit0,
    output logic                                  pmp_csr_hit1,
    output pmp_pkg::csr_data_t                    pmp_csr_rdata0,
    output pmp_pkg::csr_data_t                    pmp_csr_rdata1,
    output logic                                  pmp_we,
    output pmp_pkg::pmp_cfg_t  [`PMP_ENTRIES-1:0] entry_cfg,
    output pmp_pkg::pmp_addr_t [`PMP_ENTRIES-1:0] entry_addr
);
    import pmp_pkg::*;

    logic     [`PMP_ENTRIES-1:0] cfg_we;
    logic     [`PMP_ENTRIES-1:0] addr_we;
    pmp_cfg_t [`PMP_ENTRIES-1:0] cfg_wdata;

    // lock checks look at the current register contents
    pmp_csr_decode decode_i (
        .csr_pmp_we        (csr_pmp_we),
        .csr_pmp_waddr     (csr_pmp_waddr),
        .csr_pmp_wdata     (csr_pmp_wdata),
        .csr_cur_privilege (csr_cur_privilege),
        .entry_cfg         (entry_cfg),
        .cfg_we            (cfg_we),
        .addr_we           (addr_we),
        .cfg_wdata         (cfg_wdata)
    );

    pmp_entry_regs regs_i (
        .core_clk      (core_clk),
        .core_reset_n  (core_reset_n),
        .cfg_we        (cfg_we),
        .addr_we       (addr_we),
        .cfg_wdata     (cfg_wdata),
        .csr_pmp_wdata (csr_pmp_wdata),
        .entry_cfg     (entry_cfg),
        .entry_addr    (entry_addr),
        .pmp_we        (pmp_we)
    );

    pmp_csr_read read_i (
        .raddr0     (csr_pmp_raddr0),
        .raddr1     (csr_pmp_raddr1),
        .entry_cfg  (entry_cfg),
        .entry_addr (entry_addr),
        .hit0       (pmp_csr_hit0),
        .hit1       (pmp_csr_hit1),
        .rdata0     (pmp_csr_rdata0),
        .rdata1     (pmp_csr_rdata1)
    );

endmodule

// ==== testbench/pmp_csr_assertions.sv ====
// properties of the PMP CSR top level, sampled on core_clk and disabled while in reset
`timescale 1ns/1ps
`include "pmp_config.svh"

module pmp_csr_assertions (
    input logic                                 core_clk,
    input logic                                 core_reset_n,
    input logic                                 csr_pmp_we,
    input logic                                 pmp_we,
    input logic                                 pmp_csr_hit0,
    input logic                                 pmp_csr_hit1,
    input pmp_pkg::csr_data_t                   pmp_csr_rdata0,
    input pmp_pkg::csr_data_t                   pmp_csr_rdata1,
    input pmp_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0] entry_cfg
);
    import pmp_pkg::*;

    localparam pmp_cfg_t RESERVED_BITS = 8'h60;

    int failures = 0;

    // an accepted write always comes with a strobe one cycle earlier
    we_follows_strobe: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        pmp_we |-> $past(csr_pmp_we))
        else begin
            failures++;
            $error("pmp_we is high without a write strobe in the previous cycle");
        end

    miss_reads_zero0: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        !pmp_csr_hit0 |-> (pmp_csr_rdata0 == '0))
        else begin
            failures++;
            $error("pmp_csr_rdata0 is not zero while pmp_csr_hit0 is low");
        end

    miss_reads_zero1: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        !pmp_csr_hit1 |-> (pmp_csr_rdata1 == '0))
        else begin
            failures++;
            $error("pmp_csr_rdata1 is not zero while pmp_csr_hit1 is low");
        end

    reserved_cfg_zero: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        (entry_cfg & {`PMP_ENTRIES{RESERVED_BITS}}) == '0)
        else begin
            failures++;
            $error("an exported cfg byte has bit 6 or bit 5 set");
        end

endmodule

// ==== testbench/pmp_csr_checker.sv ====
// reference model of the PMP write rules; assumes PMP_GRANULARITY of at least 8 bytes
`timescale 1ns/1ps
`include "pmp_config.svh"

module pmp_csr_checker #(
    parameter int CHECK_DELAY = 38
) (
    input  logic                                  core_clk,
    input  logic                                  core_reset_n,
    input  pmp_pkg::priv_t                        csr_cur_privilege,
    input  logic                                  csr_pmp_we,
    input  pmp_pkg::csr_addr_t                    csr_pmp_waddr,
    input  pmp_pkg::csr_data_t                    csr_pmp_wdata,
    input  pmp_pkg::csr_addr_t                    csr_pmp_raddr0,
    input  pmp_pkg::csr_addr_t                    csr_pmp_raddr1,
    input  logic                                  pmp_csr_hit0,
    input  logic                                  pmp_csr_hit1,
    input  pmp_pkg::csr_data_t                    pmp_csr_rdata0,
    input  pmp_pkg::csr_data_t                    pmp_csr_rdata1,
    input  logic                                  pmp_we,
    input  pmp_pkg::pmp_cfg_t  [`PMP_ENTRIES-1:0] entry_cfg,
    input  pmp_pkg::pmp_addr_t [`PMP_ENTRIES-1:0] entry_addr,
    output int                                    check_count,
    output int                                    error_count
);
    import pmp_pkg::*;

    localparam csr_data_t GRAN_MASK  = csr_data_t'((1 << `PMP_G) - 1);
    localparam csr_data_t NAPOT_ONES = csr_data_t'((1 << (`PMP_G - 1)) - 1);

    pmp_cfg_t  model_cfg  [`PMP_ENTRIES];
    pmp_addr_t model_addr [`PMP_ENTRIES];
    logic      model_we;

    // number of the cfg CSR addressed, or -1 outside the cfg range
    function automatic int cfg_csr_num(csr_addr_t addr);
        int off;
        off = int'(addr) - int'(`PMP_CFG_BASE);
        return (off >= 0 && off < `PMP_CFG_CSRS) ? off : -1;
    endfunction

    function automatic int addr_csr_num(csr_addr_t addr);
        int off;
        off = int'(addr) - int'(`PMP_ADDR_BASE);
        return (off >= 0 && off < `PMP_ADDR_CSRS) ? off : -1;
    endfunction

    function automatic logic next_tor_locked(int idx);
        pmp_cfg_t next;
        if (idx + 1 >= `PMP_ENTRIES) begin
            return 1'b0;
        end
        next = model_cfg[idx + 1];
        return next[`PMPCFG_L] && (next[`PMPCFG_A_MSB:`PMPCFG_A_LSB] == `PMP_A_TOR);
    endfunction

    function automatic csr_data_t expected_read(csr_addr_t addr);
        csr_data_t data;
        int        grp;
        int        idx;
        data = '0;
        grp  = cfg_csr_num(addr);
        idx  = addr_csr_num(addr);
        if (grp >= 0) begin
            for (int k = 0; k < 4; k++) begin
                if (4 * grp + k < `PMP_ENTRIES) begin
                    data[8 * k +: 8] = model_cfg[4 * grp + k];
                end
            end
        end else if (idx >= 0 && idx < `PMP_ENTRIES) begin
            data = csr_data_t'(model_addr[idx]);
            // NAPOT keeps stored bit G-1 and reads ones below it
            if (model_cfg[idx][`PMPCFG_A_MSB:`PMPCFG_A_LSB] == `PMP_A_NAPOT) begin
                data = data | NAPOT_ONES;
            end else begin
                data = data & ~GRAN_MASK;
            end
        end
        return data;
    endfunction

    task automatic apply_write();
        pmp_cfg_t wbyte;
        int       grp;
        int       idx;
        logic     accepted;
        accepted = 1'b0;
        grp      = cfg_csr_num(csr_pmp_waddr);
        idx      = addr_csr_num(csr_pmp_waddr);
        if (csr_pmp_we && csr_cur_privilege == `PRIV_MACHINE) begin
            if (grp >= 0) begin
                for (int k = 0; k < 4; k++) begin
                    if (4 * grp + k < `PMP_ENTRIES && !model_cfg[4 * grp + k][`PMPCFG_L]) begin
                        wbyte      = csr_pmp_wdata[8 * k +: 8];
                        wbyte[6:5] = 2'b00;
                        if (wbyte[`PMPCFG_A_MSB:`PMPCFG_A_LSB] == `PMP_A_NA4) begin
                            wbyte[`PMPCFG_A_MSB:`PMPCFG_A_LSB] = `PMP_A_OFF;
                        end
                        model_cfg[4 * grp + k] = wbyte;
                        accepted = 1'b1;
                    end
                end
            end else if (idx >= 0 && idx < `PMP_ENTRIES) begin
                if (!model_cfg[idx][`PMPCFG_L] && !next_tor_locked(idx)) begin
                    model_addr[idx] = csr_pmp_wdata[`PMP_PALEN-3:0];
                    accepted = 1'b1;
                end
            end
        end
        model_we = accepted;
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s expected 0x%0h, actual 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic compare_outputs();
        check_value("pmp_csr_hit0", 32'(cfg_csr_num(csr_pmp_raddr0) >= 0 ||
                    addr_csr_num(csr_pmp_raddr0) >= 0), 32'(pmp_csr_hit0));
        check_value("pmp_csr_hit1", 32'(cfg_csr_num(csr_pmp_raddr1) >= 0 ||
                    addr_csr_num(csr_pmp_raddr1) >= 0), 32'(pmp_csr_hit1));
        check_value("pmp_csr_rdata0", expected_read(csr_pmp_raddr0), pmp_csr_rdata0);
        check_value("pmp_csr_rdata1", expected_read(csr_pmp_raddr1), pmp_csr_rdata1);
        check_value("pmp_we", 32'(model_we), 32'(pmp_we));
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            check_value($sformatf("entry_cfg[%0d]", i), 32'(model_cfg[i]), 32'(entry_cfg[i]));
            check_value($sformatf("entry_addr[%0d]", i), 32'(model_addr[i]),
                        32'(entry_addr[i]));
        end
    endtask

    // model follows the DUT at each edge from the inputs held stable across it
    always @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            for (int i = 0; i < `PMP_ENTRIES; i++) begin
                model_cfg[i]  = '0;
                model_addr[i] = '0;
            end
            model_we = 1'b0;
        end else begin
            apply_write();
        end
    end

    initial begin
        check_count = 0;
        error_count = 0;
        forever begin
            @(posedge core_clk);
            #(CHECK_DELAY);
            if (core_reset_n) begin
                compare_outputs();
            end
        end
    end

endmodule

// ==== testbench/tb_pmp_csr.sv ====
// random PMP CSR traffic from a fixed LFSR seed, with a reset before each phase to clear locks
`timescale 1ns/1ps
`include "pmp_config.svh"

module tb_pmp_csr;
    import pmp_pkg::*;

    localparam int          CLK_PERIOD     = 40;
    localparam int          DRIVE_DELAY    = 2;
    localparam int          RESET_CYCLES   = 3;
    localparam int          RUN_CYCLES     = 3000;
    localparam int          PHASES         = 6;
    localparam int          PHASE_CYCLES   = RUN_CYCLES / PHASES;
    localparam int          TIMEOUT_MARGIN = 100;
    localparam int          TIMEOUT_CYCLES = RUN_CYCLES + TIMEOUT_MARGIN;
    localparam logic [31:0] LFSR_SEED      = 32'd74087;
    localparam logic [31:0] LFSR_TAPS      = 32'h80200003;
    // windows of eight addresses around each edge of the CSR map
    localparam int EDGE_BASE [4] = '{int'(`PMP_CFG_BASE) - 4, int'(`PMP_CFG_BASE) + 4,
                                     int'(`PMP_ADDR_BASE) - 4,
                                     int'(`PMP_ADDR_BASE) + `PMP_ADDR_CSRS - 4};

    logic                          core_clk = 1'b0;
    logic                          core_reset_n;
    priv_t                         csr_cur_privilege;
    logic                          csr_pmp_we;
    csr_addr_t                     csr_pmp_waddr;
    csr_data_t                     csr_pmp_wdata;
    csr_addr_t                     csr_pmp_raddr0;
    csr_addr_t                     csr_pmp_raddr1;
    logic                          pmp_csr_hit0;
    logic                          pmp_csr_hit1;
    csr_data_t                     pmp_csr_rdata0;
    csr_data_t                     pmp_csr_rdata1;
    logic                          pmp_we;
    pmp_cfg_t  [`PMP_ENTRIES-1:0]  entry_cfg;
    pmp_addr_t [`PMP_ENTRIES-1:0]  entry_addr;
    int                            check_count;
    int                            error_count;
    int                            cycle_count;
    logic [31:0]                   lfsr_state;

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    pmp_csr dut_i (.*);

    pmp_csr_checker #(.CHECK_DELAY(CLK_PERIOD - DRIVE_DELAY)) checker_i (.*);

    bind pmp_csr pmp_csr_assertions assertions_i (
        .core_clk       (core_clk),
        .core_reset_n   (core_reset_n),
        .csr_pmp_we     (csr_pmp_we),
        .pmp_we         (pmp_we),
        .pmp_csr_hit0   (pmp_csr_hit0),
        .pmp_csr_hit1   (pmp_csr_hit1),
        .pmp_csr_rdata0 (pmp_csr_rdata0),
        .pmp_csr_rdata1 (pmp_csr_rdata1),
        .entry_cfg      (entry_cfg)
    );

    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    // one LFSR step per bit, first bit taken ends up as the MSB of the value
    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < count; b++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic pick_addr(output csr_addr_t addr);
        logic [31:0] sel;
        logic [31:0] bits;
        take_bits(3, sel);
        case (sel[2:0])
            3'd0, 3'd1: begin
                take_bits(3, bits);
                addr = csr_addr_t'(int'(`PMP_CFG_BASE) + int'(bits) % (`PMP_ENTRIES / 4));
            end
            3'd2, 3'd3, 3'd4: begin
                take_bits(5, bits);
                addr = csr_addr_t'(int'(`PMP_ADDR_BASE) + int'(bits) % `PMP_ENTRIES);
            end
            3'd5: begin
                take_bits(3, bits);
                addr = csr_addr_t'(int'(`PMP_CFG_BASE) + int'(bits));
            end
            3'd6: begin
                take_bits(5, bits);
                addr = csr_addr_t'(int'(`PMP_ADDR_BASE) + int'(bits));
            end
            default: begin
                take_bits(1, sel);
                if (sel[0]) begin
                    take_bits(12, bits);
                    addr = csr_addr_t'(bits);
                end else begin
                    take_bits(5, bits);
                    addr = csr_addr_t'(EDGE_BASE[bits[4:3]] + int'(bits[2:0]));
                end
            end
        endcase
    endtask

    task automatic drive_idle();
        csr_cur_privilege = `PRIV_MACHINE;
        csr_pmp_we        = 1'b0;
        csr_pmp_waddr     = '0;
        csr_pmp_wdata     = '0;
        csr_pmp_raddr0    = '0;
        csr_pmp_raddr1    = '0;
    endtask

    task automatic drive_random();
        logic [31:0] bits;
        logic [31:0] data;
        csr_addr_t   addr;
        take_bits(1, bits);
        csr_pmp_we = bits[0];
        take_bits(3, bits);
        if (bits[2:0] != 3'd0) begin
            csr_cur_privilege = `PRIV_MACHINE;
        end else begin
            take_bits(2, bits);
            csr_cur_privilege = priv_t'(bits[1:0]);
        end
        pick_addr(addr);
        take_bits(32, data);
        // a lock bit in a cfg write survives one draw in 64
        if (addr >= `PMP_CFG_BASE && addr < `PMP_ADDR_BASE) begin
            for (int k = 0; k < 4; k++) begin
                take_bits(6, bits);
                if (bits[5:0] != 6'h3F) begin
                    data[8 * k + `PMPCFG_L] = 1'b0;
                end
            end
        end
        csr_pmp_waddr = addr;
        csr_pmp_wdata = data;
        pick_addr(addr);
        csr_pmp_raddr0 = addr;
        pick_addr(addr);
        csr_pmp_raddr1 = addr;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge core_clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int total_errors;
        lfsr_state   = LFSR_SEED;
        core_reset_n = 1'b0;
        drive_idle();
        for (int p = 0; p < PHASES; p++) begin
            drive_idle();
            core_reset_n = 1'b0;
            repeat (RESET_CYCLES) @(posedge core_clk);
            #(DRIVE_DELAY);
            core_reset_n = 1'b1;
            repeat (PHASE_CYCLES - RESET_CYCLES) begin
                drive_random();
                @(posedge core_clk);
                #(DRIVE_DELAY);
            end
        end
        drive_idle();
        @(posedge core_clk);
        #(DRIVE_DELAY);
        total_errors = error_count + dut_i.assertions_i.failures;
        $display("summary: %0d checks, %0d compare errors, %0d assertion failures",
                 check_count, error_count, dut_i.assertions_i.failures);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+design
design/pmp_pkg.sv
design/pmp_csr_decode.sv
design/pmp_entry_regs.sv
design/pmp_csr_read.sv
design/pmp_csr.sv
testbench/pmp_csr_assertions.sv
testbench/pmp_csr_checker.sv
testbench/tb_pmp_csr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the PMP CSR testbench with Verilator, run it, then look for the pass line in sim.log.
# The error limit lets a failed assertion be counted instead of stopping the run.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_pmp_csr -f flist.f \
    && ./obj_dir/Vtb_pmp_csr +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qxF '*** PASSED ***' sim.log && echo "run_sim: pass" && exit 0 \
    || echo "run_sim: fail" && exit 1
